/* Makefile */
# Verilator build and run of the pipeline trace unit testbench

VERILATOR ?= verilator
TOP       ?= tb_pipe_trace
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --assert
PASS_STR  ?= TB PASSED

.PHONY: sim clean

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

/* rtl/hazard_monitor.sv */
// measures stall runs and flags flush cycles, one hazard record per cycle at most
`default_nettype none
`timescale 1ns/1ps

module hazard_monitor (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic              flush,
    output trace_pkg::event_t hazard
);

    // stall level one cycle back
    logic stall_q;
    // cycles in the current stall run
    logic [trace_pkg::age_w-1:0] run_len;
    // stall record waiting behind a flush record
    logic pend_valid;
    logic [trace_pkg::age_w-1:0] pend_len;
    // first low cycle after a run
    logic stall_end;

    assign stall_end = stall_q && !stall;

    ////////////////////////////////////////////////////////////
    // run counter and pending stall record
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            stall_q <= 1'b0;
            run_len <= '0;
            pend_valid <= 1'b0;
        end else begin
            stall_q <= stall;
            // restart from zero once the run is reported
            run_len <= stall ? trace_pkg::sat_inc(run_len) : '0;
            if (stall_end && (flush || pend_valid)) begin
                // output slot taken, park this run
                pend_valid <= 1'b1;
            end else if (pend_valid && !flush) begin
                pend_valid <= 1'b0;
            end
        end
    end

    // pending length, only read while pend_valid
    always_ff @(posedge clk) begin
        if (stall_end && (flush || pend_valid)) begin
            pend_len <= run_len;
        end
    end

    ////////////////////////////////////////////////////////////
    // record select: flush, then pending, then new stall end
    ////////////////////////////////////////////////////////////

    always_comb begin
        hazard = '0;
        hazard.rec.kind = trace_pkg::kind_hazard;
        if (flush) begin
            hazard.valid = 1'b1;
            hazard.rec.body.haz.cause = trace_pkg::cause_flush;
            hazard.rec.body.haz.length = trace_pkg::age_w'(1);
        end else if (pend_valid) begin
            hazard.valid = 1'b1;
            hazard.rec.body.haz.cause = trace_pkg::cause_stall;
            hazard.rec.body.haz.length = pend_len;
        end else if (stall_end) begin
            hazard.valid = 1'b1;
            hazard.rec.body.haz.cause = trace_pkg::cause_stall;
            hazard.rec.body.haz.length = run_len;
        end
    end

    // a parked run must drain before the next one lands on a flush
    a_pend_single: assert property (@(posedge clk) disable iff (rst)
        (stall_end && flush) |-> !pend_valid);

endmodule

`default_nettype wire

/* rtl/pipe_trace_top.sv */
// top of the pipeline trace unit, wires tracker and hazard monitor into the packer
`default_nettype none
`timescale 1ns/1ps

module pipe_trace_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   stall,
    input  logic                   flush,
    output logic                   trace_valid,
    output trace_pkg::trace_word_t trace_word
);

    ////////////////////////////////////////////////////////////
    // event wires
    ////////////////////////////////////////////////////////////

    // retire record from write-back
    trace_pkg::event_t retire_evt;
    // stall or flush record
    trace_pkg::event_t hazard_evt;

    // instruction tag chain
    stage_tracker u_stage_tracker (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .flush  (flush),
        .retire (retire_evt)
    );

    // stall runs and flush cycles
    hazard_monitor u_hazard_monitor (
        .clk    (clk),
        .rst    (rst),
        .stall  (stall),
        .flush  (flush),
        .hazard (hazard_evt)
    );

    // retire first, hazards in order behind it
    trace_packer u_trace_packer (
        .clk         (clk),
        .rst         (rst),
        .retire      (retire_evt),
        .hazard      (hazard_evt),
        .trace_valid (trace_valid),
        .trace_word  (trace_word)
    );

endmodule

`default_nettype wire

/* rtl/stage_tracker.sv */
// follows instruction ids and ages through the five stages and flags each retire
`default_nettype none
`timescale 1ns/1ps

module stage_tracker (
    input  logic              clk,
    input  logic              rst,
    input  logic              stall,
    input  logic              flush,
    output trace_pkg::event_t retire
);

    // slot 0 is fetch, last slot is write-back
    trace_pkg::stage_slot_t slot [trace_pkg::num_stages];
    // id handed to the next fetched instruction
    logic [trace_pkg::id_w-1:0] next_id;
    // all stage ids side by side, for the hold check
    logic [trace_pkg::num_stages*trace_pkg::id_w-1:0] id_vec;

    ////////////////////////////////////////////////////////////
    // stage chain
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < trace_pkg::num_stages; i++) begin
                slot[i] <= '0;
            end
            // first instruction sits in fetch right after reset
            slot[0].valid <= 1'b1;
            next_id <= trace_pkg::id_w'(1);
        end else if (flush) begin
            // kill everything in flight
            for (int i = 0; i < trace_pkg::num_stages; i++) begin
                slot[i].valid <= 1'b0;
            end
            // fetch still steps over one id unless stalled
            if (!stall) begin
                slot[0].id <= next_id;
                next_id <= next_id + 1'b1;
            end
        end else if (stall) begin
            // frozen, but everything in flight gets older
            for (int i = 0; i < trace_pkg::num_stages; i++) begin
                if (slot[i].valid) begin
                    slot[i].age <= trace_pkg::sat_inc(slot[i].age);
                end
            end
        end else begin
            // normal advance
            for (int i = 1; i < trace_pkg::num_stages; i++) begin
                slot[i] <= '{
                    valid: slot[i-1].valid,
                    id:    slot[i-1].id,
                    age:   slot[i-1].valid ? trace_pkg::sat_inc(slot[i-1].age)
                                           : slot[i-1].age
                };
            end
            // fresh fetch starts at age 0
            slot[0] <= '{valid: 1'b1, id: next_id, age: '0};
            next_id <= next_id + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // retire record
    ////////////////////////////////////////////////////////////

    // write-back leaves only on a clean cycle
    always_comb begin
        retire = '0;
        retire.valid = slot[trace_pkg::num_stages-1].valid && !stall && !flush;
        retire.rec.kind = trace_pkg::kind_retire;
        retire.rec.body.ret.id = slot[trace_pkg::num_stages-1].id;
        retire.rec.body.ret.latency = slot[trace_pkg::num_stages-1].age;
    end

    always_comb begin
        for (int i = 0; i < trace_pkg::num_stages; i++) begin
            id_vec[i*trace_pkg::id_w +: trace_pkg::id_w] = slot[i].id;
        end
    end

    // anything past fetch has been through at least one edge
    for (genvar g = 1; g < trace_pkg::num_stages; g++) begin : g_age_chk
        a_age_nonzero: assert property (@(posedge clk) disable iff (rst)
            slot[g].valid |-> (slot[g].age != '0));
    end

    // stall freezes every id and the fetch counter, flush or not
    a_stall_ids_hold: assert property (@(posedge clk) disable iff (rst)
        stall |=> ($stable(id_vec) && $stable(next_id)));

endmodule

`default_nettype wire

/* rtl/trace_packer.sv */
// merges retire and hazard events into one registered 16-bit trace word stream
`default_nettype none
`timescale 1ns/1ps

module trace_packer (
    input  logic                   clk,
    input  logic                   rst,
    input  trace_pkg::event_t      retire,
    input  trace_pkg::event_t      hazard,
    output logic                   trace_valid,
    output trace_pkg::trace_word_t trace_word
);

    // one-entry hold for a hazard that lost the slot
    trace_pkg::trace_word_t hold_word;
    logic hold_valid;
    // hazard goes to the hold instead of the output
    logic hold_load;
    logic hold_valid_next;
    // word chosen for the output register
    trace_pkg::trace_word_t sel_word;
    logic sel_valid;

    ////////////////////////////////////////////////////////////
    // arbitration
    ////////////////////////////////////////////////////////////

    // new hazard loses to a retire or to an older held entry
    assign hold_load = hazard.valid && (retire.valid || hold_valid);

    // held entry stays only while retires keep winning
    assign hold_valid_next = hold_load || (hold_valid && retire.valid);

    assign sel_valid = retire.valid || hold_valid || hazard.valid;

    always_comb begin
        if (retire.valid) begin
            sel_word = retire.rec;
        end else if (hold_valid) begin
            sel_word = hold_word;
        end else begin
            // also the idle value, ignored with sel_valid low
            sel_word = hazard.rec;
        end
    end

    ////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            trace_valid <= 1'b0;
            hold_valid <= 1'b0;
        end else begin
            trace_valid <= sel_valid;
            hold_valid <= hold_valid_next;
        end
    end

    // payload, qualified by the valids above
    always_ff @(posedge clk) begin
        trace_word <= sel_word;
        if (hold_load) begin
            hold_word <= hazard.rec;
        end
    end

    // no second hazard may queue behind a blocked entry
    a_hold_no_overrun: assert property (@(posedge clk) disable iff (rst)
        (hold_load && retire.valid) |-> !hold_valid);

endmodule

`default_nettype wire

/* rtl/trace_pkg.sv */
// shared widths, kind codes and record types of the pipeline trace unit, taken by scoped name
`default_nettype none

package trace_pkg;

    ////////////////////////////////////////////////////////////
    // widths and limits
    ////////////////////////////////////////////////////////////

    // instruction id, wraps modulo 64
    localparam int id_w = 6;
    // ages and run lengths, saturating
    localparam int age_w = 8;
    localparam logic [age_w-1:0] age_max = '1;
    // fetch, decode, execute, memory, write-back
    localparam int num_stages = 5;
    localparam int kind_w = 2;
    localparam int rsvd_w = 5;

    // record kinds in the top bits of a trace word
    localparam logic [kind_w-1:0] kind_retire = 2'd1;
    localparam logic [kind_w-1:0] kind_hazard = 2'd2;

    // hazard causes
    localparam logic cause_stall = 1'b0;
    localparam logic cause_flush = 1'b1;

    ////////////////////////////////////////////////////////////
    // record types
    ////////////////////////////////////////////////////////////

    // content of one pipeline stage
    typedef struct packed {
        logic             valid;
        logic [id_w-1:0]  id;
        logic [age_w-1:0] age;
    } stage_slot_t;

    typedef struct packed {
        logic [id_w-1:0]  id;
        logic [age_w-1:0] latency;
    } retire_rec_t;

    // rsvd stays zero so both views are 14 bits
    typedef struct packed {
        logic              cause;
        logic [rsvd_w-1:0] rsvd;
        logic [age_w-1:0]  length;
    } hazard_rec_t;

    // one body, decoded by the kind field
    typedef union packed {
        retire_rec_t ret;
        hazard_rec_t haz;
    } trace_body_u;

    typedef struct packed {
        logic [kind_w-1:0] kind;
        trace_body_u       body;
    } trace_word_t;

    // producer to packer hand-off, kind filled at the source
    typedef struct packed {
        logic        valid;
        trace_word_t rec;
    } event_t;

    // +1 that sticks at the top value
    function automatic logic [age_w-1:0] sat_inc(input logic [age_w-1:0] v);
        return (v == age_max) ? v : v + 1'b1;
    endfunction

endpackage

`default_nettype wire

/* sim.f */
rtl/trace_pkg.sv
rtl/stage_tracker.sv
rtl/hazard_monitor.sv
rtl/trace_packer.sv
rtl/pipe_trace_top.sv
verif/tb_pipe_trace.sv

/* verif/tb_pipe_trace.sv */
// testbench for pipe_trace_top, file-driven cases then a random run against a cycle model
`default_nettype none
`timescale 1ns/1ps

module tb_pipe_trace;

    localparam int clk_period = 8;
    localparam int reset_cycles = 16;
    localparam int max_file_cycles = 400;
    localparam int rand_cycles = 400;
    localparam int drain_cycles = 4;
    // upper bound on the whole run, in cycles
    localparam int total_cycles = 2 * reset_cycles + max_file_cycles + rand_cycles
                                  + 2 * drain_cycles;

    logic clk;
    logic rst;
    logic stall;
    logic flush;
    logic trace_valid;
    trace_pkg::trace_word_t trace_word;

    // words still to be seen on the output
    logic [15:0] exp_q [$];

    // file segments
    int seg_stall [$];
    int seg_flush [$];
    int seg_len [$];

    ////////////////////////////////////////////////////////////
    // cycle model state
    ////////////////////////////////////////////////////////////

    int m_valid [trace_pkg::num_stages];
    int m_id [trace_pkg::num_stages];
    int m_age [trace_pkg::num_stages];
    int m_next;
    int m_stall_q;
    int m_run;
    int m_pend_v;
    int m_pend_len;
    int m_hold_v;
    logic [15:0] m_hold_w;
    // model predictions only in the random phase
    bit model_on;

    pipe_trace_top uut (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (flush),
        .trace_valid (trace_valid),
        .trace_word  (trace_word)
    );

    always #(clk_period / 2) clk = ~clk;

    function automatic int sat8(input int v);
        return (v >= 255) ? 255 : v + 1;
    endfunction

    function automatic logic [15:0] stall_word(input int len);
        return {2'd2, 1'b0, 5'd0, 8'(len)};
    endfunction

    task automatic model_reset();
        for (int i = 0; i < trace_pkg::num_stages; i++) begin
            m_valid[i] = 0;
            m_id[i] = 0;
            m_age[i] = 0;
        end
        m_valid[0] = 1;
        m_next = 1;
        m_stall_q = 0;
        m_run = 0;
        m_pend_v = 0;
        m_pend_len = 0;
        m_hold_v = 0;
        m_hold_w = '0;
    endtask

    // one clock of the model, pushes the word that leaves this cycle
    task automatic model_step(input int s, input int f);
        bit ret_v;
        bit haz_v;
        bit stall_end;
        bit load;
        logic [15:0] ret_w;
        logic [15:0] haz_w;
        ret_v = m_valid[trace_pkg::num_stages-1] != 0 && s == 0 && f == 0;
        ret_w = {2'd1, 6'(m_id[trace_pkg::num_stages-1]),
                 8'(m_age[trace_pkg::num_stages-1])};
        stall_end = m_stall_q != 0 && s == 0;
        haz_v = 1'b1;
        if (f != 0) begin
            haz_w = {2'd2, 1'b1, 5'd0, 8'd1};
        end else if (m_pend_v != 0) begin
            haz_w = stall_word(m_pend_len);
        end else if (stall_end) begin
            haz_w = stall_word(m_run);
        end else begin
            haz_v = 1'b0;
            haz_w = '0;
        end
        // retire wins, older held hazard next
        if (ret_v) begin
            exp_q.push_back(ret_w);
        end else if (m_hold_v != 0) begin
            exp_q.push_back(m_hold_w);
        end else if (haz_v) begin
            exp_q.push_back(haz_w);
        end
        load = haz_v && (ret_v || m_hold_v != 0);
        m_hold_v = (load || (m_hold_v != 0 && ret_v)) ? 1 : 0;
        if (load) begin
            m_hold_w = haz_w;
        end
        // stall end parked behind a flush or a pending record
        if (stall_end && (f != 0 || m_pend_v != 0)) begin
            m_pend_v = 1;
            m_pend_len = m_run;
        end else if (m_pend_v != 0 && f == 0) begin
            m_pend_v = 0;
        end
        m_run = (s != 0) ? sat8(m_run) : 0;
        m_stall_q = s;
        // stage chain
        if (f != 0) begin
            for (int i = 0; i < trace_pkg::num_stages; i++) begin
                m_valid[i] = 0;
            end
            if (s == 0) begin
                m_id[0] = m_next;
                m_next = (m_next + 1) % 64;
            end
        end else if (s != 0) begin
            for (int i = 0; i < trace_pkg::num_stages; i++) begin
                if (m_valid[i] != 0) begin
                    m_age[i] = sat8(m_age[i]);
                end
            end
        end else begin
            for (int i = trace_pkg::num_stages - 1; i > 0; i--) begin
                m_valid[i] = m_valid[i-1];
                m_id[i] = m_id[i-1];
                m_age[i] = (m_valid[i-1] != 0) ? sat8(m_age[i-1]) : m_age[i-1];
            end
            m_valid[0] = 1;
            m_id[0] = m_next;
            m_age[0] = 0;
            m_next = (m_next + 1) % 64;
        end
    endtask

    // inputs change 1 ns after the edge
    task automatic run_cycle(input int s, input int f);
        stall = s[0];
        flush = f[0];
        if (model_on) begin
            model_step(s, f);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        rst = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    task automatic load_cases();
        int fd;
        int n;
        int a;
        int b;
        int c;
        logic [15:0] w;
        logic [8*8-1:0] tok;
        logic [8*128-1:0] rest;
        fd = $fopen("verif/trace_cases.txt", "r");
        assert (fd != 0) else begin
            $display("could not open the case file verif/trace_cases.txt");
            $display("TB FAILED");
            $fatal(1);
        end
        while (!$feof(fd)) begin
            tok = '0;
            n = $fscanf(fd, "%s", tok);
            if (n == 1) begin
                if (tok == "#") begin
                    n = $fgets(rest, fd);
                end else if (tok == "S") begin
                    n = $fscanf(fd, "%d %d %d", a, b, c);
                    seg_stall.push_back(a);
                    seg_flush.push_back(b);
                    seg_len.push_back(c);
                end else if (tok == "E") begin
                    n = $fscanf(fd, "%h", w);
                    exp_q.push_back(w);
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////
    // output checker
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        logic [15:0] want;
        if (!rst && trace_valid) begin
            assert (exp_q.size() != 0) else begin
                $display("trace word %h arrived at %0t when none was expected",
                         trace_word, $time);
                $display("TB FAILED");
                $fatal(1);
            end
            want = exp_q.pop_front();
            assert (trace_word === want) else begin
                $display("[FAIL] t=%0t trace_word expected %h actual %h",
                         $time, want, trace_word);
                $display("TB FAILED");
                $fatal(1);
            end
        end
    end

    // run bound from the phase lengths
    initial begin
        #((total_cycles + 100) * clk_period);
        $display("watchdog expired before the test sequence finished");
        $display("TB FAILED");
        $fatal(1);
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int seg_total;
        clk = 1'b0;
        rst = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        model_on = 1'b0;
        void'($urandom(32'h9b8b_b6f4));
        model_reset();
        load_cases();
        seg_total = 0;
        foreach (seg_len[i]) begin
            seg_total += seg_len[i];
        end
        assert (seg_total <= max_file_cycles) else begin
            $display("case file asks for %0d cycles, more than the run allows", seg_total);
            $display("TB FAILED");
            $fatal(1);
        end
        apply_reset();

        // phase 1, segments from the case file
        foreach (seg_len[i]) begin
            repeat (seg_len[i]) run_cycle(seg_stall[i], seg_flush[i]);
        end
        @(negedge clk);
        #1;
        assert (exp_q.size() == 0) else begin
            $display("%0d words from the case file never appeared", exp_q.size());
            $display("TB FAILED");
            $fatal(1);
        end

        // phase 2, random levels against the model
        apply_reset();
        model_reset();
        model_on = 1'b1;
        repeat (rand_cycles) begin
            run_cycle(($urandom % 4) == 0, ($urandom % 10) == 0);
        end
        // stalled tail, no retire so held records drain
        repeat (drain_cycles) run_cycle(1, 0);
        @(negedge clk);
        @(negedge clk);
        #1;

        if (exp_q.size() == 0) begin
            $display("TB PASSED");
            $finish;
        end else begin
            $display("%0d predicted words never appeared", exp_q.size());
            $display("TB FAILED");
            $fatal(1);
        end
    end

endmodule

`default_nettype wire

/* verif/trace_cases.txt */
# S <stall> <flush> <cycles> drives one segment of inputs
# E <hex word> is the next trace word expected on the output
# idle fill, ids 0 and 1 retire with latency 4
S 0 0 6
E 4004 E 4104
# three stall cycles, then retires at latency 7 with the stall record held behind
S 1 0 3
S 0 0 5
E 4207 E 4307 E 4407 E 4507 E 4607
# single flush drains the held stall record, flush record goes to hold
S 0 1 1
E 8003
# refill, id 12 skipped by the flush
S 0 0 6
E a001 E 4d04
# stall and flush together, then the stall end record
S 1 1 2
E a001 E a001
S 0 0 7
E 8002 E 5304 E 5404
# long stall saturates both latency and run length
S 1 0 300
S 0 0 1
E 55ff
# quiet tail lets the held record out
S 1 0 3
E 80ff
